//--- soc_params.svh
`ifndef SOC_PARAMS_SVH
`define SOC_PARAMS_SVH

// Memory sizes
`define SOC_RAM_WORDS 1024
`define SOC_RAM_BYTES 32'd4096
`define SOC_WBUF_DEPTH 4

// Top-level regions, address bits 31:28
`define SOC_REGION_RAM 4'h2
`define SOC_REGION_IO 4'h5

// Devices behind the I/O bridge, address bits 27:24
`define SOC_DEV_TIMER 4'h5
`define SOC_DEV_SYSREG 4'h9

// Identity and reset values
`define SOC_DEVICE_ID 32'd1
`define SOC_TIMER_CMP_RESET 32'hffff_ffff

`endif

//--- soc_pkg.sv
package soc_pkg;

	// Bus payload
	typedef logic [31:0] bus_addr_t;
	typedef logic [31:0] bus_data_t;

	// Region or device number
	typedef logic [3:0] region_t;

	// Word indices
	typedef logic [9:0] ram_index_t;
	typedef logic [1:0] reg_index_t;

	typedef logic [9:0] led_t;

	typedef enum logic [1:0] {
		DEC_IDLE,
		DEC_WAIT,
		DEC_RESP
	} dec_state_t;

endpackage

//--- soc_bus_if.sv
interface soc_bus_if
	import soc_pkg::*;
();
	logic      req;
	logic      we;
	bus_addr_t adr;
	bus_data_t wdat;
	bus_data_t rdat;
	logic      ready;

	// Request side
	modport master (
		output req, we, adr, wdat,
		input  rdat, ready
	);

	// Response side, ready is a one-cycle pulse
	modport slave (
		input  req, we, adr, wdat,
		output rdat, ready
	);

endinterface

//--- ram_array.sv
`include "soc_params.svh"

module ram_array
	import soc_pkg::*;
(
	input logic      clock,
	soc_bus_if.slave bus
);
	bus_data_t  mem [`SOC_RAM_WORDS];
	ram_index_t idx;
	logic       access;

	// Upper bits inside the region alias
	assign idx    = bus.adr[11:2];
	assign access = bus.req && !bus.ready;

	always_ff @(posedge clock) begin
		bus.ready <= access;
		if (access) begin
			if (bus.we)
				mem[idx] <= bus.wdat;
			bus.rdat <= mem[idx];
		end
	end

endmodule

//--- ram_write_buffer.sv
`include "soc_params.svh"

module ram_write_buffer
	import soc_pkg::*;
(
	input  logic      clock,
	input  logic      i_rst_n,
	soc_bus_if.slave  up,
	soc_bus_if.master mem
);
	localparam int PTR_W = $clog2(`SOC_WBUF_DEPTH);
	localparam logic [PTR_W:0] FULL_COUNT = `SOC_WBUF_DEPTH;

	bus_addr_t        fifo_adr [`SOC_WBUF_DEPTH];
	bus_data_t        fifo_dat [`SOC_WBUF_DEPTH];
	logic [PTR_W-1:0] head;
	logic [PTR_W-1:0] tail;
	logic [PTR_W:0]   count;
	logic             push;
	logic             pop;
	logic             mem_done;
	logic             issue_wr;
	logic             issue_rd;

	// Upstream write accepted while a slot is free
	assign push     = up.req && up.we && !up.ready && (count != FULL_COUNT);
	assign mem_done = mem.req && mem.ready;
	assign pop      = mem_done && mem.we;
	assign issue_wr = !mem.req && (count != '0);
	// Reads only after every queued write has landed
	assign issue_rd = up.req && !up.we && !up.ready && !mem.req && (count == '0);

	always_ff @(posedge clock or negedge i_rst_n) begin
		if (!i_rst_n) begin
			head     <= '0;
			tail     <= '0;
			count    <= '0;
			up.ready <= 1'b0;
			mem.req  <= 1'b0;
		end else begin
			up.ready <= push || (mem_done && !mem.we);
			if (push)
				tail <= tail + 1'b1;
			if (pop)
				head <= head + 1'b1;
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
			if (mem_done)
				mem.req <= 1'b0;
			else if (issue_wr || issue_rd)
				mem.req <= 1'b1;
		end
	end

	// ============================================================
	// Storage and downstream payload
	always_ff @(posedge clock) begin
		if (push) begin
			fifo_adr[tail] <= up.adr;
			fifo_dat[tail] <= up.wdat;
		end
		// Held stable while mem.req is high
		if (!mem.req) begin
			mem.we   <= issue_wr;
			mem.adr  <= issue_wr ? fifo_adr[head] : up.adr;
			mem.wdat <= fifo_dat[head];
		end
		if (mem_done)
			up.rdat <= mem.rdat;
	end

endmodule

//--- sys_timer.sv
`include "soc_params.svh"

module sys_timer
	import soc_pkg::*;
(
	input  logic     clock,
	input  logic     i_rst_n,
	soc_bus_if.slave bus,
	output logic     o_timer_irq
);
	bus_data_t  count;
	bus_data_t  cmp;
	reg_index_t idx;
	logic       access;

	assign idx    = bus.adr[3:2];
	assign access = bus.req && !bus.ready;

	always_ff @(posedge clock or negedge i_rst_n) begin
		if (!i_rst_n) begin
			count       <= '0;
			cmp         <= `SOC_TIMER_CMP_RESET;
			o_timer_irq <= 1'b0;
			bus.ready   <= 1'b0;
		end else begin
			bus.ready <= access;
			// Level interrupt, follows the compare
			o_timer_irq <= (count >= cmp);
			if (access && bus.we && idx == 2'd0)
				count <= bus.wdat;
			else
				count <= count + 1'b1;
			if (access && bus.we && idx == 2'd1)
				cmp <= bus.wdat;
		end
	end

	always_ff @(posedge clock) begin
		if (access) begin
			case (idx)
				2'd0:    bus.rdat <= count;
				2'd1:    bus.rdat <= cmp;
				default: bus.rdat <= '0;
			endcase
		end
	end

endmodule

//--- sys_registers.sv
`include "soc_params.svh"

module sys_registers
	import soc_pkg::*;
(
	input  logic     clock,
	input  logic     i_rst_n,
	soc_bus_if.slave bus,
	output led_t     o_leds
);
	reg_index_t idx;
	logic       access;

	assign idx    = bus.adr[3:2];
	assign access = bus.req && !bus.ready;

	always_ff @(posedge clock or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_leds    <= '0;
			bus.ready <= 1'b0;
		end else begin
			bus.ready <= access;
			// Only the LED word is writable
			if (access && bus.we && idx == 2'd2)
				o_leds <= bus.wdat[9:0];
		end
	end

	always_ff @(posedge clock) begin
		if (access) begin
			case (idx)
				2'd0:    bus.rdat <= `SOC_DEVICE_ID;
				2'd1:    bus.rdat <= `SOC_RAM_BYTES;
				2'd2:    bus.rdat <= {22'd0, o_leds};
				default: bus.rdat <= '0;
			endcase
		end
	end

endmodule

//--- io_bridge.sv
`include "soc_params.svh"

module io_bridge
	import soc_pkg::*;
(
	input  logic      clock,
	input  logic      i_rst_n,
	soc_bus_if.slave  near,
	soc_bus_if.master timer,
	soc_bus_if.master sysreg
);
	logic      far_active;
	bus_addr_t far_adr;
	bus_data_t far_wdat;
	logic      far_we;
	region_t   far_dev;
	logic      far_ready;
	bus_data_t far_rdat;

	assign far_dev = far_adr[27:24];

	assign timer.req    = far_active && (far_dev == `SOC_DEV_TIMER);
	assign timer.we     = far_we;
	assign timer.adr    = far_adr;
	assign timer.wdat   = far_wdat;
	assign sysreg.req   = far_active && (far_dev == `SOC_DEV_SYSREG);
	assign sysreg.we    = far_we;
	assign sysreg.adr   = far_adr;
	assign sysreg.wdat  = far_wdat;

	// Response merge, undecoded devices answer at once with zero
	always_comb begin
		case (far_dev)
			`SOC_DEV_TIMER: begin
				far_ready = timer.ready;
				far_rdat  = timer.rdat;
			end
			`SOC_DEV_SYSREG: begin
				far_ready = sysreg.ready;
				far_rdat  = sysreg.rdat;
			end
			default: begin
				far_ready = far_active;
				far_rdat  = '0;
			end
		endcase
	end

	always_ff @(posedge clock or negedge i_rst_n) begin
		if (!i_rst_n) begin
			far_active <= 1'b0;
			near.ready <= 1'b0;
		end else if (near.ready) begin
			near.ready <= 1'b0;
		end else if (far_active) begin
			if (far_ready) begin
				far_active <= 1'b0;
				near.ready <= 1'b1;
			end
		end else if (near.req) begin
			far_active <= 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		// Capture near request while idle
		if (!far_active && !near.ready) begin
			far_adr  <= near.adr;
			far_we   <= near.we;
			far_wdat <= near.wdat;
		end
		if (far_active && far_ready)
			near.rdat <= far_rdat;
	end

endmodule

//--- bus_decoder.sv
`include "soc_params.svh"

module bus_decoder
	import soc_pkg::*;
(
	input  logic      clock,
	input  logic      i_rst_n,
	input  logic      i_wb_cyc,
	input  logic      i_wb_stb,
	input  logic      i_wb_we,
	input  bus_addr_t i_wb_adr,
	input  bus_data_t i_wb_dat,
	output bus_data_t o_wb_dat,
	output logic      o_wb_ack,
	output logic      o_wb_err,
	soc_bus_if.master ram,
	soc_bus_if.master near
);
	dec_state_t state;
	bus_addr_t  req_adr;
	bus_data_t  req_wdat;
	logic       req_we;
	region_t    req_region;
	logic       sel_ram;
	logic       sel_io;

	assign req_region = req_adr[31:28];
	assign sel_ram    = (req_region == `SOC_REGION_RAM);
	assign sel_io     = (req_region == `SOC_REGION_IO);

	// Same payload on both buses, only the selected one sees req
	assign ram.req   = (state == DEC_WAIT) && sel_ram;
	assign ram.we    = req_we;
	assign ram.adr   = req_adr;
	assign ram.wdat  = req_wdat;
	assign near.req  = (state == DEC_WAIT) && sel_io;
	assign near.we   = req_we;
	assign near.adr  = req_adr;
	assign near.wdat = req_wdat;

	always_ff @(posedge clock or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state    <= DEC_IDLE;
			o_wb_ack <= 1'b0;
			o_wb_err <= 1'b0;
		end else begin
			case (state)
				DEC_IDLE: begin
					if (i_wb_cyc && i_wb_stb)
						state <= DEC_WAIT;
				end
				DEC_WAIT: begin
					// Unmapped region never reaches a slave
					if (!sel_ram && !sel_io) begin
						o_wb_err <= 1'b1;
						state    <= DEC_RESP;
					end else if ((sel_ram && ram.ready) || (sel_io && near.ready)) begin
						o_wb_ack <= 1'b1;
						state    <= DEC_RESP;
					end
				end
				DEC_RESP: begin
					o_wb_ack <= 1'b0;
					o_wb_err <= 1'b0;
					state    <= DEC_IDLE;
				end
				default: state <= DEC_IDLE;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (state == DEC_IDLE) begin
			req_adr  <= i_wb_adr;
			req_wdat <= i_wb_dat;
			req_we   <= i_wb_we;
		end
		// Last value before leaving DEC_WAIT is the response data
		if (state == DEC_WAIT)
			o_wb_dat <= sel_ram ? ram.rdat : (sel_io ? near.rdat : '0);
	end

endmodule

//--- soc_fabric.sv
module soc_fabric
	import soc_pkg::*;
(
	input  logic      clock,
	input  logic      i_rst_n,
	input  logic      i_wb_cyc,
	input  logic      i_wb_stb,
	input  logic      i_wb_we,
	input  bus_addr_t i_wb_adr,
	input  bus_data_t i_wb_dat,
	output bus_data_t o_wb_dat,
	output logic      o_wb_ack,
	output logic      o_wb_err,
	output logic      o_timer_irq,
	output led_t      o_leds
);

	soc_bus_if ram_bus();
	soc_bus_if mem_bus();
	soc_bus_if near_bus();
	soc_bus_if timer_bus();
	soc_bus_if sysreg_bus();

	// ============================================================
	// Wishbone entry and region decode
	bus_decoder u_decoder (
		.clock    (clock),
		.i_rst_n  (i_rst_n),
		.i_wb_cyc (i_wb_cyc),
		.i_wb_stb (i_wb_stb),
		.i_wb_we  (i_wb_we),
		.i_wb_adr (i_wb_adr),
		.i_wb_dat (i_wb_dat),
		.o_wb_dat (o_wb_dat),
		.o_wb_ack (o_wb_ack),
		.o_wb_err (o_wb_err),
		.ram      (ram_bus),
		.near     (near_bus)
	);

	// ============================================================
	// RAM region
	ram_write_buffer u_wbuf (.clock(clock), .i_rst_n(i_rst_n), .up(ram_bus), .mem(mem_bus));
	ram_array u_ram (.clock(clock), .bus(mem_bus));

	// ============================================================
	// I/O region
	io_bridge u_bridge (
		.clock   (clock),
		.i_rst_n (i_rst_n),
		.near    (near_bus),
		.timer   (timer_bus),
		.sysreg  (sysreg_bus)
	);
	sys_timer u_timer (.clock(clock), .i_rst_n(i_rst_n), .bus(timer_bus), .o_timer_irq(o_timer_irq));
	sys_registers u_sysreg (.clock(clock), .i_rst_n(i_rst_n), .bus(sysreg_bus), .o_leds(o_leds));

endmodule

//--- soc_fabric_chk.sv
module soc_fabric_chk (
	input logic clock,
	input logic i_rst_n,
	input logic i_wb_stb,
	input logic o_wb_ack,
	input logic o_wb_err,
	input logic o_timer_irq
);
	timeunit 1ns;
	timeprecision 1ps;

	// At most one kind of response per transfer
	ack_err_exclusive: assert property (@(posedge clock) disable iff (!i_rst_n)
		!(o_wb_ack && o_wb_err))
		else $error("o_wb_ack and o_wb_err high together");

	// Response only while the strobe is held
	ack_needs_stb: assert property (@(posedge clock) disable iff (!i_rst_n)
		(o_wb_ack || o_wb_err) |-> i_wb_stb)
		else $error("acknowledge without i_wb_stb");

	ack_one_cycle: assert property (@(posedge clock) disable iff (!i_rst_n)
		o_wb_ack |=> !o_wb_ack)
		else $error("o_wb_ack longer than one cycle");

	err_one_cycle: assert property (@(posedge clock) disable iff (!i_rst_n)
		o_wb_err |=> !o_wb_err)
		else $error("o_wb_err longer than one cycle");

	reset_quiet: assert property (@(posedge clock)
		!i_rst_n |-> (!o_wb_ack && !o_wb_err && !o_timer_irq))
		else $error("outputs active during reset");

endmodule

//--- tb_soc_fabric.sv
`include "soc_params.svh"

module tb_soc_fabric
	import soc_pkg::*;
();
	timeunit 1ns;
	timeprecision 1ps;

	localparam int CLK_PERIOD    = 20;
	localparam int ACK_LIMIT     = 64;
	localparam int PREFILL_OPS   = 16;
	localparam int RAM_OPS       = 200;
	localparam int BURST_WRITES  = 8;
	localparam int BURST_READS   = 3;
	localparam int UNMAPPED_OPS  = 10;
	localparam int SYSREG_ROUNDS = 2;
	// Single accesses of the unmapped, sysreg and timer tests
	localparam int FIXED_OPS     = 2 + 3 + 4;
	localparam int TOTAL_OPS     = PREFILL_OPS + RAM_OPS + BURST_WRITES + BURST_READS
		+ UNMAPPED_OPS + 4 * SYSREG_ROUNDS + FIXED_OPS;

	logic      clock = 1'b0;
	logic      i_rst_n;
	logic      i_wb_cyc;
	logic      i_wb_stb;
	logic      i_wb_we;
	bus_addr_t i_wb_adr;
	bus_data_t i_wb_dat;
	bus_data_t o_wb_dat;
	logic      o_wb_ack;
	logic      o_wb_err;
	logic      o_timer_irq;
	led_t      o_leds;

	logic [31:0] lfsr;
	bus_data_t   ram_model [`SOC_RAM_WORDS];
	ram_index_t  idx_pool [PREFILL_OPS];
	led_t        led_model;
	int          errors = 0;
	int          checks = 0;
	int          tests = 0;
	int          test_start_errors;
	string       test_name;

	soc_fabric UUT (.*);

	bind soc_fabric soc_fabric_chk u_chk (
		.clock       (clock),
		.i_rst_n     (i_rst_n),
		.i_wb_stb    (i_wb_stb),
		.o_wb_ack    (o_wb_ack),
		.o_wb_err    (o_wb_err),
		.o_timer_irq (o_timer_irq)
	);

	always #(CLK_PERIOD / 2) clock = ~clock;

	// ============================================================
	// Random source, Galois form of x^32+x^22+x^2+x+1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_step(lfsr);
			v = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	// Upper bits 27:12 alias inside the RAM region
	function automatic bus_addr_t ram_addr(input ram_index_t idx, input logic [15:0] upper);
		return {`SOC_REGION_RAM, upper, idx, 2'b00};
	endfunction

	function automatic bus_addr_t io_addr(input region_t dev, input reg_index_t off);
		return {`SOC_REGION_IO, dev, 20'h0, off, 2'b00};
	endfunction

	// ============================================================
	// Compare tasks
	task automatic check_data(input string name, input bus_data_t exp, input bus_data_t act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("MISMATCH %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	task automatic check_leds(input string name, input led_t exp, input led_t act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("MISMATCH %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("MISMATCH %s: expected %b, actual %b", name, exp, act);
		end
	endtask

	task automatic start_test(input string name);
		test_name = name;
		test_start_errors = errors;
		tests++;
	endtask

	task automatic finish_test();
		$display("test %s finished with %0d errors", test_name, errors - test_start_errors);
	endtask

	// ============================================================
	// Wishbone master, called 1 ns after a rising edge
	task automatic bus_transfer(input string name, input logic we, input bus_addr_t adr,
			input bus_data_t wdat, output bus_data_t rdat, output logic ack, output logic err);
		int cycles;
		cycles = 0;
		i_wb_cyc = 1'b1;
		i_wb_stb = 1'b1;
		i_wb_we  = we;
		i_wb_adr = adr;
		i_wb_dat = wdat;
		do begin
			@(posedge clock);
			#1;
			cycles++;
		end while (!o_wb_ack && !o_wb_err && cycles < ACK_LIMIT);
		ack  = o_wb_ack;
		err  = o_wb_err;
		rdat = o_wb_dat;
		// Strobe drops in the cycle after the acknowledge
		@(posedge clock);
		#1;
		i_wb_cyc = 1'b0;
		i_wb_stb = 1'b0;
		i_wb_we  = 1'b0;
		if (!ack && !err) begin
			errors++;
			$display("ERROR: %s got no acknowledge within %0d cycles", name, ACK_LIMIT);
		end
		// One idle cycle between transfers
		@(posedge clock);
		#1;
	endtask

	task automatic bus_write(input string name, input bus_addr_t adr, input bus_data_t dat);
		bus_data_t rdat;
		logic      ack;
		logic      err;
		bus_transfer(name, 1'b1, adr, dat, rdat, ack, err);
		check_flag({name, " ack"}, 1'b1, ack);
		// Model takes the word on the acknowledge
		if (ack && adr[31:28] == `SOC_REGION_RAM)
			ram_model[adr[11:2]] = dat;
	endtask

	task automatic bus_read(input string name, input bus_addr_t adr, output bus_data_t dat);
		logic ack;
		logic err;
		bus_transfer(name, 1'b0, adr, '0, dat, ack, err);
		check_flag({name, " ack"}, 1'b1, ack);
	endtask

	// ============================================================
	// Test sequence
	initial begin
		bus_data_t  rd;
		bus_data_t  wd;
		bus_data_t  cnt;
		bus_data_t  cmp;
		ram_index_t idx;
		region_t    region;
		logic       ack;
		logic       err;
		int         waited;

		lfsr     = 32'h1e6ffb0b;
		i_rst_n  = 1'b1;
		i_wb_cyc = 1'b0;
		i_wb_stb = 1'b0;
		i_wb_we  = 1'b0;
		i_wb_adr = '0;
		i_wb_dat = '0;
		#1 i_rst_n = 1'b0;
		repeat (10) @(posedge clock);
		#1 i_rst_n = 1'b1;
		@(posedge clock);
		#1;

		start_test("ram_random");
		// Indices spread over the whole RAM, reused by the random traffic
		for (int i = 0; i < PREFILL_OPS; i++) begin
			idx_pool[i] = ram_index_t'(rand_bits(10));
			bus_write("ram prefill", ram_addr(idx_pool[i], 16'(rand_bits(16))), rand_bits(32));
		end
		for (int i = 0; i < RAM_OPS; i++) begin
			idx = idx_pool[4'(rand_bits(4))];
			if (rand_bits(1) == 32'd1) begin
				bus_write("ram random write", ram_addr(idx, 16'(rand_bits(16))), rand_bits(32));
			end else begin
				bus_read("ram random read", ram_addr(idx, 16'(rand_bits(16))), rd);
				check_data("ram random read", ram_model[idx], rd);
			end
		end
		finish_test();

		start_test("write_burst");
		for (int i = 0; i < BURST_WRITES; i++)
			bus_write("burst write",
				ram_addr(ram_index_t'(20 + i % BURST_READS), 16'(rand_bits(16))),
				rand_bits(32));
		for (int i = 0; i < BURST_READS; i++) begin
			bus_read("burst read", ram_addr(ram_index_t'(20 + i), 16'h0), rd);
			check_data("burst read", ram_model[20 + i], rd);
		end
		finish_test();

		start_test("unmapped");
		for (int i = 0; i < UNMAPPED_OPS; i++) begin
			region = region_t'(rand_bits(4));
			if (region == `SOC_REGION_RAM || region == `SOC_REGION_IO)
				region = 4'h0;
			bus_transfer("unmapped access", rand_bits(1) == 32'd1,
				{region, 16'(rand_bits(16)), idx_pool[0], 2'b00}, rand_bits(32), rd, ack, err);
			check_flag("unmapped err", 1'b1, err);
			check_flag("unmapped ack", 1'b0, ack);
		end
		bus_read("ram after unmapped", ram_addr(idx_pool[0], 16'h0), rd);
		check_data("ram after unmapped", ram_model[idx_pool[0]], rd);
		bus_transfer("undecoded device", 1'b0, io_addr(4'h3, 2'd0), '0, rd, ack, err);
		check_flag("undecoded ack", 1'b1, ack);
		check_flag("undecoded err", 1'b0, err);
		check_data("undecoded data", 32'd0, rd);
		finish_test();

		start_test("sysregs");
		for (int round = 0; round < SYSREG_ROUNDS; round++) begin
			bus_read("sysreg id", io_addr(`SOC_DEV_SYSREG, 2'd0), rd);
			check_data("sysreg id", `SOC_DEVICE_ID, rd);
			bus_read("sysreg ram size", io_addr(`SOC_DEV_SYSREG, 2'd1), rd);
			check_data("sysreg ram size", `SOC_RAM_BYTES, rd);
			bus_write("sysreg id write", io_addr(`SOC_DEV_SYSREG, 2'd0), rand_bits(32));
			bus_write("sysreg size write", io_addr(`SOC_DEV_SYSREG, 2'd1), rand_bits(32));
		end
		wd = rand_bits(32);
		bus_write("led write", io_addr(`SOC_DEV_SYSREG, 2'd2), wd);
		led_model = led_t'(wd);
		check_leds("led output", led_model, o_leds);
		bus_read("led readback", io_addr(`SOC_DEV_SYSREG, 2'd2), rd);
		check_data("led readback", {22'd0, led_model}, rd);
		bus_read("sysreg offset 3", io_addr(`SOC_DEV_SYSREG, 2'd3), rd);
		check_data("sysreg offset 3", 32'd0, rd);
		finish_test();

		start_test("timer");
		check_flag("irq after reset", 1'b0, o_timer_irq);
		bus_read("timer count", io_addr(`SOC_DEV_TIMER, 2'd0), cnt);
		cmp = cnt + 32'd50;
		bus_write("timer compare", io_addr(`SOC_DEV_TIMER, 2'd1), cmp);
		waited = 0;
		while (!o_timer_irq && waited < 100) begin
			@(posedge clock);
			#1;
			waited++;
		end
		check_flag("irq rises", 1'b1, o_timer_irq);
		bus_read("timer count late", io_addr(`SOC_DEV_TIMER, 2'd0), cnt);
		check_flag("count past compare", 1'b1, cnt >= cmp);
		bus_write("timer compare reset", io_addr(`SOC_DEV_TIMER, 2'd1), 32'hffff_ffff);
		waited = 0;
		while (o_timer_irq && waited < 3) begin
			@(posedge clock);
			#1;
			waited++;
		end
		check_flag("irq falls", 1'b0, o_timer_irq);
		finish_test();

		$display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

	// Watchdog, 40 cycles per operation
	initial begin
		#(TOTAL_OPS * 40 * CLK_PERIOD);
		$display("ERROR: watchdog timeout, the tests did not finish in time");
		$display("FAIL: see errors above");
		$finish;
	end

endmodule

//--- verilog.f
+incdir+.
soc_pkg.sv
soc_bus_if.sv
ram_array.sv
ram_write_buffer.sv
sys_timer.sv
sys_registers.sv
io_bridge.sv
bus_decoder.sv
soc_fabric.sv
soc_fabric_chk.sv
tb_soc_fabric.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module tb_soc_fabric -f verilog.f -o sim_tb

./obj_dir/sim_tb 2>&1 | tee sim.log

if grep -q "FAIL: see errors above" sim.log; then
	echo "simulation failed, see sim.log"
	exit 1
fi
echo "simulation finished without failures"
